//--- common/decode_pkg.sv
package decode_pkg;

    localparam int NUM_WARPS     = 4;
    localparam int NUM_THREADS   = 4;
    localparam int CSR_ADDR_BITS = 12;

    typedef logic [31:0]                    instr_t;
    typedef logic [31:0]                    word_t;    // XLEN data, PC, immediate
    typedef logic [4:0]                     reg_num_t;
    typedef logic [$clog2(NUM_WARPS)-1:0]   wid_t;
    typedef logic [NUM_THREADS-1:0]         tmask_t;
    typedef logic [15:0]                    uuid_t;
    typedef logic [3:0]                     op_type_t;
    typedef logic [2:0]                     op_mod_t;

    // RV32 major opcodes
    typedef enum logic [6:0] {
        OP_L      = 7'b0000011,
        OP_FENCE  = 7'b0001111,
        OP_I      = 7'b0010011,
        OP_AUIPC  = 7'b0010111,
        OP_S      = 7'b0100011,
        OP_R      = 7'b0110011,
        OP_LUI    = 7'b0110111,
        OP_B      = 7'b1100011,
        OP_JALR   = 7'b1100111,
        OP_JAL    = 7'b1101111,
        OP_SYS    = 7'b1110011
    } opcode_e;

    typedef enum logic [1:0] {
        EX_NONE = 2'd0,
        EX_ALU  = 2'd1,
        EX_LSU  = 2'd2,
        EX_CSR  = 2'd3
    } ex_unit_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_LUI, ALU_AUIPC
    } alu_op_e;

    typedef enum logic [3:0] {
        BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU, BR_JAL, BR_JALR,
        BR_ECALL, BR_EBREAK, BR_URET, BR_SRET, BR_MRET
    } br_op_e;

    typedef enum logic [3:0] {
        MUL_MUL, MUL_MULH, MUL_MULHSU, MUL_MULHU,
        MUL_DIV, MUL_DIVU, MUL_REM, MUL_REMU
    } mul_op_e;

    localparam op_type_t LSU_FENCE = 4'd15;

    localparam op_mod_t MOD_BR  = 3'b001;  // Branch or jump class
    localparam op_mod_t MOD_MUL = 3'b010;  // Multiply or divide

    typedef struct packed {
        uuid_t  uuid;
        wid_t   wid;
        tmask_t tmask;
        word_t  pc;
        instr_t instr;
    } fetch_t;

    typedef struct packed {
        uuid_t    uuid;
        wid_t     wid;
        tmask_t   tmask;
        word_t    pc;
        ex_unit_e ex_type;
        op_type_t op_type;
        op_mod_t  op_mod;
        logic     wb;
        reg_num_t rd;
        reg_num_t rs1;
        reg_num_t rs2;
        word_t    imm;
        logic     use_pc;
        logic     use_imm;
    } uop_t;

    typedef struct packed {
        wid_t wid;
        logic is_wstall;
    } sched_t;

endpackage

//--- decode/imm_gen.sv
`timescale 1ns/1ps

module imm_gen import decode_pkg::*; (
    input  instr_t instr,
    output word_t  i_imm,
    output word_t  s_imm,
    output word_t  b_imm,
    output word_t  u_imm,
    output word_t  j_imm,
    output word_t  csr_imm
);

    logic is_shift;

    // SLLI / SRLI / SRAI carry funct7 in the upper immediate bits
    assign is_shift = (instr[6:0] == OP_I) && (instr[13:12] == 2'b01);

    assign i_imm = is_shift ? {27'b0, instr[24:20]}
                            : {{20{instr[31]}}, instr[31:20]};

    assign s_imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};

    assign b_imm = {{19{instr[31]}}, instr[31], instr[7],
                    instr[30:25], instr[11:8], 1'b0};

    assign u_imm = {instr[31:12], 12'b0};

    assign j_imm = {{11{instr[31]}}, instr[31], instr[19:12],
                    instr[20], instr[30:21], 1'b0};

    // Address low, zimm above it
    assign csr_imm = {{(32 - CSR_ADDR_BITS - 5){1'b0}}, instr[19:15],
                      instr[31:20]};

endmodule

//--- decode/funct_map.sv
`timescale 1ns/1ps

module funct_map import decode_pkg::*; (
    input  instr_t   instr,
    output op_type_t alu_op,
    output op_type_t br_op,
    output op_type_t sys_op,
    output op_type_t mul_op
);

    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [11:0] funct12;

    assign funct3  = instr[14:12];
    assign funct7  = instr[31:25];
    assign funct12 = instr[31:20];

    always_comb begin
        case (funct3)
            3'h0: alu_op = (instr[5] && funct7[5]) ? ALU_SUB : ALU_ADD;  // bit 5 set only for OP
            3'h1: alu_op = ALU_SLL;
            3'h2: alu_op = ALU_SLT;
            3'h3: alu_op = ALU_SLTU;
            3'h4: alu_op = ALU_XOR;
            3'h5: alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
            3'h6: alu_op = ALU_OR;
            default: alu_op = ALU_AND;
        endcase
    end

    always_comb begin
        case (funct3)
            3'h0: br_op = BR_EQ;
            3'h1: br_op = BR_NE;
            3'h4: br_op = BR_LT;
            3'h5: br_op = BR_GE;
            3'h6: br_op = BR_LTU;
            3'h7: br_op = BR_GEU;
            default: br_op = '0;
        endcase
    end

    always_comb begin
        case (funct12)
            12'h000: sys_op = BR_ECALL;
            12'h001: sys_op = BR_EBREAK;
            12'h002: sys_op = BR_URET;
            12'h102: sys_op = BR_SRET;
            12'h302: sys_op = BR_MRET;
            default: sys_op = '0;
        endcase
    end

    // M ops follow funct3 order directly
    assign mul_op = {1'b0, funct3};

endmodule

//--- decode/op_decoder.sv
`timescale 1ns/1ps

module op_decoder import decode_pkg::*; (
    input  fetch_t fetch,
    output uop_t   uop,
    output logic   is_wstall
);

    instr_t   instr;
    logic [2:0] funct3;
    word_t    i_imm, s_imm, b_imm, u_imm, j_imm, csr_imm;
    op_type_t alu_op, br_op, sys_op, mul_op;
    logic     use_rd;

    assign instr  = fetch.instr;
    assign funct3 = instr[14:12];

    imm_gen u_imm_gen (
        .instr   (instr),
        .i_imm   (i_imm),
        .s_imm   (s_imm),
        .b_imm   (b_imm),
        .u_imm   (u_imm),
        .j_imm   (j_imm),
        .csr_imm (csr_imm)
    );

    funct_map u_funct_map (
        .instr  (instr),
        .alu_op (alu_op),
        .br_op  (br_op),
        .sys_op (sys_op),
        .mul_op (mul_op)
    );

    always_comb begin
        uop       = '0;
        uop.uuid  = fetch.uuid;
        uop.wid   = fetch.wid;
        uop.tmask = fetch.tmask;
        uop.pc    = fetch.pc;
        use_rd    = 1'b0;
        is_wstall = 1'b0;

        case (instr[6:0])
            OP_I: begin
                uop.ex_type = EX_ALU;
                uop.op_type = alu_op;
                uop.use_imm = 1'b1;
                uop.imm     = i_imm;
                uop.rd      = instr[11:7];
                uop.rs1     = instr[19:15];
                use_rd      = 1'b1;
            end
            OP_R: begin
                uop.ex_type = EX_ALU;
                if (instr[25]) begin  // M extension
                    uop.op_type = mul_op;
                    uop.op_mod  = MOD_MUL;
                end else begin
                    uop.op_type = alu_op;
                end
                uop.rd  = instr[11:7];
                uop.rs1 = instr[19:15];
                uop.rs2 = instr[24:20];
                use_rd  = 1'b1;
            end
            OP_LUI, OP_AUIPC: begin
                uop.ex_type = EX_ALU;
                uop.op_type = instr[5] ? ALU_LUI : ALU_AUIPC;
                uop.use_pc  = ~instr[5];
                uop.use_imm = 1'b1;
                uop.imm     = u_imm;
                uop.rd      = instr[11:7];
                use_rd      = 1'b1;
            end
            OP_JAL, OP_JALR: begin
                uop.ex_type = EX_ALU;
                uop.op_type = instr[3] ? BR_JAL : BR_JALR;
                uop.op_mod  = MOD_BR;
                uop.use_pc  = instr[3];
                uop.use_imm = 1'b1;
                uop.imm     = instr[3] ? j_imm : i_imm;
                uop.rd      = instr[11:7];
                uop.rs1     = instr[3] ? 5'd0 : instr[19:15];
                use_rd      = 1'b1;
                is_wstall   = 1'b1;
            end
            OP_B: begin
                uop.ex_type = EX_ALU;
                uop.op_type = br_op;
                uop.op_mod  = MOD_BR;
                uop.use_pc  = 1'b1;
                uop.use_imm = 1'b1;
                uop.imm     = b_imm;
                uop.rs1     = instr[19:15];
                uop.rs2     = instr[24:20];
                is_wstall   = 1'b1;
            end
            OP_L: begin
                uop.ex_type = EX_LSU;
                uop.op_type = {1'b0, funct3};
                uop.imm     = i_imm;
                uop.rd      = instr[11:7];
                uop.rs1     = instr[19:15];
                use_rd      = 1'b1;
            end
            OP_S: begin
                uop.ex_type = EX_LSU;
                uop.op_type = {1'b1, funct3};
                uop.imm     = s_imm;
                uop.rs1     = instr[19:15];
                uop.rs2     = instr[24:20];
            end
            OP_FENCE: begin
                uop.ex_type = EX_LSU;
                uop.op_type = LSU_FENCE;
            end
            OP_SYS: begin
                uop.rd = instr[11:7];
                use_rd = 1'b1;
                if (funct3[1:0] != 2'b00) begin
                    uop.ex_type = EX_CSR;
                    uop.op_type = {2'b00, funct3[1:0]};
                    uop.use_imm = funct3[2];
                    if (funct3[2]) begin
                        uop.imm = csr_imm;
                    end else begin
                        uop.imm = {20'b0, csr_imm[CSR_ADDR_BITS-1:0]};
                        uop.rs1 = instr[19:15];
                    end
                end else begin
                    uop.ex_type = EX_ALU;  // Trap and return go down the branch path
                    uop.op_type = sys_op;
                    uop.op_mod  = MOD_BR;
                    uop.use_pc  = 1'b1;
                    uop.use_imm = 1'b1;
                    uop.imm     = 32'd4;
                    is_wstall   = 1'b1;
                end
            end
            default: is_wstall = 1'b1;  // Unknown op, hold the warp
        endcase

        uop.wb = use_rd && (uop.rd != 5'd0);
    end

endmodule

//--- verilog/decode_reg.sv
`timescale 1ns/1ps

module decode_reg import decode_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic in_valid,
    input  uop_t in_uop,
    input  logic out_ready,
    output logic in_ready,
    output logic out_valid,
    output uop_t out_uop
);

    logic full;
    uop_t held;

    // Empty slot or draining this cycle
    assign in_ready = ~full | out_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            full <= 1'b0;
        end else if (in_ready) begin
            full <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            held <= in_uop;
        end
    end

    assign out_valid = full;
    assign out_uop   = held;

endmodule

//--- verilog/decode_stage.sv
`timescale 1ns/1ps

module decode_stage import decode_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   fetch_valid,
    input  fetch_t fetch_data,
    input  logic   uop_ready,
    output logic   fetch_ready,
    output logic   uop_valid,
    output uop_t   uop_data,
    output logic   sched_valid,
    output sched_t sched_data
);

    uop_t dec_uop;
    logic dec_wstall;

    op_decoder u_op_decoder (
        .fetch     (fetch_data),
        .uop       (dec_uop),
        .is_wstall (dec_wstall)
    );

    decode_reg u_decode_reg (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (fetch_valid),
        .in_uop    (dec_uop),
        .out_ready (uop_ready),
        .in_ready  (fetch_ready),
        .out_valid (uop_valid),
        .out_uop   (uop_data)
    );

    // One strobe per accepted fetch
    assign sched_valid          = fetch_valid && fetch_ready;
    assign sched_data.wid       = fetch_data.wid;
    assign sched_data.is_wstall = dec_wstall;

endmodule

//--- tests/decode_checker.sv
`timescale 1ns/1ps

module decode_checker import decode_pkg::*; #(
    parameter int MAX_RECS = 32
) (
    input  logic   clk,
    input  logic   rst,
    input  logic   fetch_valid,
    input  logic   fetch_ready,
    input  logic   uop_valid,
    input  logic   uop_ready,
    input  uop_t   uop_data,
    input  logic   sched_valid,
    input  sched_t sched_data,
    input  int     num_records,
    input  uop_t   exp_uop [MAX_RECS],
    input  logic   exp_wstall [MAX_RECS],
    output int     checked,
    output int     passed,
    output int     errors
);

    int   n_checked = 0;
    int   n_passed  = 0;
    int   n_errors  = 0;
    int   in_idx    = 0;
    logic rst_q     = 1'b0;
    logic stalled   = 1'b0;  // Output held back at the last edge
    uop_t stalled_uop;
    logic rec_bad [MAX_RECS] = '{default: 1'b0};

    assign checked = n_checked;
    assign passed  = n_passed;
    assign errors  = n_errors;

    task automatic compare_field(input string name, input logic [31:0] exp_val,
                                 input logic [31:0] act_val, input int idx);
        if (exp_val !== act_val) begin
            $display("CHECK FAILED at %0t: %s expected %h, got %h (record %0d)",
                     $time, name, exp_val, act_val, idx);
            n_errors++;
            rec_bad[idx] = 1'b1;
        end
    endtask

    task automatic protocol_fault(input string what);
        $display("Protocol fault at %0t: %s", $time, what);
        n_errors++;
    endtask

    task automatic compare_uop(input int idx);
        uop_t e;
        e = exp_uop[idx];
        compare_field("uop_data.uuid", 32'(e.uuid), 32'(uop_data.uuid), idx);
        compare_field("uop_data.wid", 32'(e.wid), 32'(uop_data.wid), idx);
        compare_field("uop_data.tmask", 32'(e.tmask), 32'(uop_data.tmask), idx);
        compare_field("uop_data.pc", e.pc, uop_data.pc, idx);
        compare_field("uop_data.ex_type", 32'(e.ex_type), 32'(uop_data.ex_type), idx);
        compare_field("uop_data.op_type", 32'(e.op_type), 32'(uop_data.op_type), idx);
        compare_field("uop_data.op_mod", 32'(e.op_mod), 32'(uop_data.op_mod), idx);
        compare_field("uop_data.wb", 32'(e.wb), 32'(uop_data.wb), idx);
        compare_field("uop_data.rd", 32'(e.rd), 32'(uop_data.rd), idx);
        compare_field("uop_data.rs1", 32'(e.rs1), 32'(uop_data.rs1), idx);
        compare_field("uop_data.rs2", 32'(e.rs2), 32'(uop_data.rs2), idx);
        compare_field("uop_data.imm", e.imm, uop_data.imm, idx);
        compare_field("uop_data.use_pc", 32'(e.use_pc), 32'(uop_data.use_pc), idx);
        compare_field("uop_data.use_imm", 32'(e.use_imm), 32'(uop_data.use_imm), idx);
    endtask

    always @(posedge clk) begin
        if (rst && sched_valid) begin
            protocol_fault("sched_valid is high during reset");
        end
        if (rst_q && uop_valid) begin
            protocol_fault("uop_valid is high right after reset");
        end
        if (!rst) begin
            if (stalled && !uop_valid) begin
                protocol_fault("uop_valid dropped before the micro-op was taken");
            end else if (stalled && uop_data !== stalled_uop) begin
                $display("CHECK FAILED at %0t: uop_data expected %h, got %h (held under stall)",
                         $time, stalled_uop, uop_data);
                n_errors++;
            end
            if (fetch_ready !== (!uop_valid || uop_ready)) begin
                $display("CHECK FAILED at %0t: fetch_ready expected %b, got %b",
                         $time, !uop_valid || uop_ready, fetch_ready);
                n_errors++;
            end
            if (sched_valid !== (fetch_valid && fetch_ready)) begin
                protocol_fault("sched_valid does not match a fetch transfer");
            end
            if (fetch_valid && fetch_ready) begin
                if (in_idx >= num_records) begin
                    protocol_fault("fetch transfer beyond the last record");
                end else begin
                    compare_field("sched_data.wid", 32'(exp_uop[in_idx].wid),
                                  32'(sched_data.wid), in_idx);
                    compare_field("sched_data.is_wstall", 32'(exp_wstall[in_idx]),
                                  32'(sched_data.is_wstall), in_idx);
                end
                in_idx++;
            end
            if (uop_valid && uop_ready) begin
                if (n_checked >= num_records) begin
                    protocol_fault("extra micro-op after the last record");
                end else begin
                    compare_uop(n_checked);
                    if (!rec_bad[n_checked]) begin
                        n_passed++;
                    end
                    $display("Test %0d pc %h: %s", n_checked, uop_data.pc,
                             rec_bad[n_checked] ? "FAILED" : "ok");
                    n_checked++;
                end
            end
            stalled     = uop_valid && !uop_ready;
            stalled_uop = uop_data;
        end
        rst_q = rst;
    end

endmodule

//--- tests/tb_decode_stage.sv
`timescale 1ns/1ps

module tb_decode_stage import decode_pkg::*; ();

    localparam int          CLK_PERIOD   = 4;
    localparam int          RESET_CYCLES = 8;
    localparam int          MAX_RECS     = 32;
    localparam int          FIELDS       = 15;  // Values per stimulus line
    localparam string       STIM_FILE    = "tests/decode_stimulus.txt";
    localparam logic [31:0] LFSR_SEED    = 32'h9b5a7e12;
    localparam int          STALL_IN_16  = 5;   // About 30 percent

    logic        clk = 1'b0;
    logic        rst;
    logic        fetch_valid;
    fetch_t      fetch_data;
    logic        uop_ready = 1'b1;
    logic        fetch_ready;
    logic        uop_valid;
    uop_t        uop_data;
    logic        sched_valid;
    sched_t      sched_data;

    logic [31:0] stim [MAX_RECS*FIELDS];
    fetch_t      rec_fetch [MAX_RECS];
    uop_t        exp_uop [MAX_RECS];
    logic        exp_wstall [MAX_RECS];
    int          num_records = 0;
    logic        loaded = 1'b0;
    logic        load_failed = 1'b0;
    logic [31:0] lfsr = LFSR_SEED;
    int          checked, passed, errors;

    always #(CLK_PERIOD / 2) clk = ~clk;

    decode_stage DUT (
        .clk         (clk),
        .rst         (rst),
        .fetch_valid (fetch_valid),
        .fetch_data  (fetch_data),
        .uop_ready   (uop_ready),
        .fetch_ready (fetch_ready),
        .uop_valid   (uop_valid),
        .uop_data    (uop_data),
        .sched_valid (sched_valid),
        .sched_data  (sched_data)
    );

    decode_checker #(.MAX_RECS(MAX_RECS)) u_checker (
        .clk         (clk),
        .rst         (rst),
        .fetch_valid (fetch_valid),
        .fetch_ready (fetch_ready),
        .uop_valid   (uop_valid),
        .uop_ready   (uop_ready),
        .uop_data    (uop_data),
        .sched_valid (sched_valid),
        .sched_data  (sched_data),
        .num_records (num_records),
        .exp_uop     (exp_uop),
        .exp_wstall  (exp_wstall),
        .checked     (checked),
        .passed      (passed),
        .errors      (errors)
    );

    function automatic logic [31:0] fill_value(input int a);
        return 32'ha5a50000 ^ 32'(a);
    endfunction

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic draw_bits(input int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++) begin
            value = (value << 1) | int'(lfsr[0]);
            lfsr  = lfsr_next(lfsr);
        end
    endtask

    task automatic load_stimulus();
        fetch_t f;
        uop_t   u;
        int     b;
        for (int a = 0; a < MAX_RECS * FIELDS; a++) begin
            stim[a] = fill_value(a);
        end
        $readmemh(STIM_FILE, stim);
        while (num_records < MAX_RECS &&
               stim[num_records*FIELDS] != fill_value(num_records * FIELDS)) begin
            b         = num_records * FIELDS;
            f.uuid    = 16'(num_records);
            f.wid     = stim[b][1:0];
            f.tmask   = stim[b+1][3:0];
            f.pc      = stim[b+2];
            f.instr   = stim[b+3];
            u         = '0;
            u.uuid    = f.uuid;   // Fetch tags pass straight through
            u.wid     = f.wid;
            u.tmask   = f.tmask;
            u.pc      = f.pc;
            u.ex_type = ex_unit_e'(stim[b+4][1:0]);
            u.op_type = stim[b+5][3:0];
            u.op_mod  = stim[b+6][2:0];
            u.wb      = stim[b+7][0];
            u.rd      = stim[b+8][4:0];
            u.rs1     = stim[b+9][4:0];
            u.rs2     = stim[b+10][4:0];
            u.imm     = stim[b+11];
            u.use_pc  = stim[b+12][0];
            u.use_imm = stim[b+13][0];
            rec_fetch[num_records]  = f;
            exp_uop[num_records]    = u;
            exp_wstall[num_records] = stim[b+14][0];
            num_records++;
        end
        if (num_records == 0) begin
            $display("No stimulus records could be read from %s", STIM_FILE);
            load_failed = 1'b1;
        end
    endtask

    // Random issue-side back-pressure
    always @(negedge clk) begin
        int pick;
        draw_bits(4, pick);
        uop_ready = (pick >= STALL_IN_16);
    end

    initial begin
        rst         = 1'b1;
        fetch_valid = 1'b0;
        fetch_data  = '0;
        load_stimulus();
        loaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < num_records; i++) begin
            fetch_valid = 1'b1;
            fetch_data  = rec_fetch[i];
            @(posedge clk);
            while (!fetch_ready) @(posedge clk);  // Hold until taken
            @(negedge clk);
        end
        fetch_valid = 1'b0;
        fetch_data  = '0;
        wait (checked == num_records);
        repeat (4) @(posedge clk);
        $display("Summary: %0d tests, %0d passed, %0d failed, %0d errors",
                 num_records, passed, checked - passed, errors);
        if (errors == 0 && !load_failed) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    initial begin
        wait (loaded);
        repeat (num_records * 20 + 100) @(posedge clk);
        $display("Timeout: only %0d of %0d micro-ops came out of the DUT", checked, num_records);
        $display("Errors found");
        $finish;
    end

endmodule

//--- rv_decode.f
common/decode_pkg.sv
decode/imm_gen.sv
decode/funct_map.sv
decode/op_decoder.sv
verilog/decode_reg.sv
verilog/decode_stage.sv
tests/decode_checker.sv
tests/tb_decode_stage.sv

//--- Makefile
VERILATOR ?= verilator
SIM_FLAGS ?= --binary --timing
LINT_FLAGS ?= --lint-only --timing
TOP       := tb_decode_stage
RTL_TOP   := decode_stage
FILELIST  := rv_decode.f
OBJ_DIR   := obj_dir
PASS_MSG  := No errors

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- tests/decode_stimulus.txt
// wid tmask pc instr, then expected: ex_type op_type op_mod wb rd rs1 rs2 imm use_pc use_imm
// last column is the expected is_wstall; all values hex
0 f 00001000 002081b3 1 0 0 1 03 01 02 00000000 0 0 0
1 3 00001004 40628233 1 1 0 1 04 05 06 00000000 0 0 0
2 8 00001008 409453b3 1 7 0 1 07 08 09 00000000 0 0 0
3 f 0000100c 009453b3 1 6 0 1 07 08 09 00000000 0 0 0
0 1 00001010 ffb58513 1 0 0 1 0a 0b 00 fffffffb 0 1 0
1 f 00001014 ffb58013 1 0 0 0 00 0b 00 fffffffb 0 1 0
2 6 00001018 4036d613 1 7 0 1 0c 0d 00 00000003 0 1 0
3 f 0000101c 01f09093 1 2 0 1 01 01 00 0000001f 0 1 0
0 f 00001020 027302b3 1 0 2 1 05 06 07 00000000 0 0 0
1 c 00001024 02a4f433 1 7 2 1 08 09 0a 00000000 0 0 0
2 f 00001028 123457b7 1 a 0 1 0f 00 00 12345000 0 1 0
3 5 0000102c fffff017 1 b 0 0 00 00 00 fffff000 1 1 0
0 f 00001030 ff9ff0ef 1 6 1 1 01 00 00 fffffff8 1 1 1
1 f 00001034 00008067 1 7 1 0 00 01 00 00000000 0 1 1
2 3 00001038 00208863 1 0 1 0 00 01 02 00000010 1 1 1
3 f 0000103c fe41fee3 1 5 1 0 00 03 04 fffffffc 1 1 1
0 f 00001040 ffc12483 2 2 0 1 09 02 00 fffffffc 0 0 0
1 9 00001044 007402a3 2 8 0 0 00 08 07 00000005 0 0 0
2 f 00001048 fe112023 2 a 0 0 00 02 01 ffffffe0 0 0 0
3 f 0000104c 0ff0000f 2 f 0 0 00 00 00 00000000 0 0 0
0 f 00001050 00000073 1 8 1 0 00 00 00 00000004 1 1 1
1 2 00001054 00100073 1 9 1 0 00 00 00 00000004 1 1 1
2 f 00001058 00200073 1 a 1 0 00 00 00 00000004 1 1 1
3 f 0000105c 10200073 1 b 1 0 00 00 00 00000004 1 1 1
0 f 00001060 30200073 1 c 1 0 00 00 00 00000004 1 1 1
1 f 00001064 300312f3 3 1 0 1 05 06 00 00000300 0 0 0
2 f 00001068 341fe073 3 2 0 0 00 00 00 0001f341 0 1 0
3 a 0000106c 1234568b 0 0 0 0 00 00 00 00000000 0 0 1
